// File: swap_bits.svh
`ifndef SWAP_BITS_SVH
`define SWAP_BITS_SVH

// Reverses the bit order of a vector, so abcdefgh becomes hgfedcba.
// Use it as the right-hand side of an assignment
`define SWAP_BITS(v) {<< {v}}

`endif

// File: board_pkg.sv
package board_pkg;

    localparam int w_seg = 8;  // Segments a to g plus the dot
    localparam int w_hex = 4;  // Bits per shown digit

    typedef struct packed {
        logic             pause;  // Lab key 0
        logic             down;   // Lab key 1
        logic [w_hex-1:0] step;   // Switches 3 to 0
    } count_ctrl_t;

    // Active-high pattern, bit 7 is segment a, bit 0 is the dot
    function automatic logic [w_seg-1:0] hex_to_abcdefgh (input logic [w_hex-1:0] hex);
        logic [w_seg-1:0] seg;

        case (hex)
            4'h0: seg = 8'b1111_1100;
            4'h1: seg = 8'b0110_0000;
            4'h2: seg = 8'b1101_1010;
            4'h3: seg = 8'b1111_0010;
            4'h4: seg = 8'b0110_0110;
            4'h5: seg = 8'b1011_0110;
            4'h6: seg = 8'b1011_1110;
            4'h7: seg = 8'b1110_0000;
            4'h8: seg = 8'b1111_1110;
            4'h9: seg = 8'b1111_0110;
            4'ha: seg = 8'b1110_1110;
            4'hb: seg = 8'b0011_1110;  // Lower case b
            4'hc: seg = 8'b1001_1100;
            4'hd: seg = 8'b0111_1010;  // Lower case d
            4'he: seg = 8'b1001_1110;
            4'hf: seg = 8'b1000_1110;
        endcase

        return seg;
    endfunction

endpackage

// File: slow_clk_gen.sv
`timescale 1ns/1ps

module slow_clk_gen
#(
    parameter fast_clk_mhz = 50,
    parameter slow_clk_hz  = 1
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_clk
);

    localparam half_period = fast_clk_mhz * 1000000 / (2 * slow_clk_hz);
    localparam w_cnt       = half_period > 1 ? $clog2 (half_period) : 1;

    logic [w_cnt - 1:0] cnt;
    logic               wrap;

    assign wrap = cnt == w_cnt' (half_period - 1);  // Last cycle of a half period

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end else if (wrap) begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;
        end else begin
            cnt      <= cnt + 1'b1;
        end
    end

endmodule

// File: seven_segment_display.sv
`timescale 1ns/1ps

module seven_segment_display
#(
    parameter w_digit   = 8,
    parameter w_refresh = 16
)
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [w_digit * board_pkg::w_hex - 1:0] number,
    output logic [board_pkg::w_seg - 1:0]          abcdefgh,
    output logic [w_digit - 1:0]                   digit
);

    import board_pkg::*;

    localparam w_idx = w_digit > 1 ? $clog2 (w_digit) : 1;

    logic [w_refresh - 1:0] refresh_cnt;
    logic [w_idx - 1:0]     digit_idx;
    logic [w_idx - 1:0]     next_idx;
    logic                   step_digit;
    logic [w_hex - 1:0]     nibble;

    // One step per 2^w_refresh cycles
    assign step_digit = &refresh_cnt;

    assign next_idx = digit_idx == w_idx' (w_digit - 1) ? '0 : digit_idx + 1'b1;

    assign nibble = number [digit_idx * w_hex +: w_hex];  // Nibble of the digit now lit

    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_cnt <= '0;
            digit_idx   <= '0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;

            if (step_digit) begin
                digit_idx <= next_idx;
            end
        end
    end

    // Both outputs load from the same index on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            digit    <= w_digit' (1);
            abcdefgh <= hex_to_abcdefgh ('0);
        end else begin
            digit    <= w_digit' (1) << digit_idx;
            abcdefgh <= hex_to_abcdefgh (nibble);
        end
    end

endmodule

// File: lab_top.sv
`timescale 1ns/1ps

module lab_top
#(
    parameter clk_mhz   = 50,
    parameter w_key     = 4,
    parameter w_sw      = 16,
    parameter w_led     = 16,
    parameter w_digit   = 8,
    parameter w_refresh = 16
)
(
    input  logic                           clk,
    input  logic                           slow_clk,
    input  logic                           rst,

    input  board_pkg::count_ctrl_t         ctrl,
    input  logic [w_key - 1:0]             key,

    output logic [w_led - 1:0]             led,

    output logic [board_pkg::w_seg - 1:0]  abcdefgh,
    output logic [w_digit - 1:0]           digit
);

    import board_pkg::*;

    localparam w_cnt = w_digit * w_hex;  // One nibble per display digit

    // Keys 0 and 1 reach the counter packed into ctrl, the last key is reset
    if (w_key < 3 || w_sw < w_hex || w_led > w_cnt || clk_mhz < 1) begin : g_param_check
        $error ("lab_top parameters do not fit the counter");
    end

    logic               slow_clk_q;
    logic               slow_rise;
    logic [w_cnt - 1:0] count;
    logic [w_cnt - 1:0] step_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            slow_clk_q <= 1'b0;
        end else begin
            slow_clk_q <= slow_clk;
        end
    end

    assign slow_rise = slow_clk & ~slow_clk_q;  // High for one clk cycle per slow period

    assign step_ext = w_cnt' (ctrl.step);

    // Wraps modulo 2^w_cnt in both directions
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (slow_rise && !ctrl.pause) begin
            if (ctrl.down) begin
                count <= count - step_ext;
            end else begin
                count <= count + step_ext;
            end
        end
    end

    assign led = count [w_led - 1:0];

    seven_segment_display
    #(
        .w_digit   ( w_digit   ),
        .w_refresh ( w_refresh )
    )
    i_seven_segment_display
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .number    ( count     ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     )
    );

endmodule

// File: board_specific_top.sv
`timescale 1ns/1ps

`include "swap_bits.svh"

module board_specific_top
#(
    parameter clk_mhz     = 50,
    parameter slow_clk_hz = 1,

    parameter w_key       = 4,
    parameter w_sw        = 16,
    parameter w_led       = 16,
    parameter w_digit     = 8,
    parameter w_refresh   = 16
)
(
    input  logic                           CLK,

    input  logic [w_key - 1:0]             KEY,  // Active low
    input  logic [w_sw  - 1:0]             SW,
    output logic [w_led - 1:0]             LED,

    output logic [board_pkg::w_seg - 1:0]  HGFEDCBA,  // Active low
    output logic [w_digit - 1:0]           DIGIT
);

    import board_pkg::*;

    logic                 clk;
    logic                 rst;
    logic [w_key - 1:0]   lab_key;
    count_ctrl_t          ctrl;

    logic                 slow_clk;
    logic [w_led - 1:0]   lab_led;
    logic [w_digit - 1:0] lab_digit;
    logic [w_seg - 1:0]   abcdefgh;
    logic [w_seg - 1:0]   hgfedcba;

    assign clk     = CLK;
    assign lab_key = ~KEY;
    assign rst     = lab_key [w_key - 1];  // Last key is the reset

    assign ctrl = '{
        pause : lab_key [0],
        down  : lab_key [1],
        step  : SW [w_hex - 1:0]
    };

    slow_clk_gen
    #(
        .fast_clk_mhz ( clk_mhz     ),
        .slow_clk_hz  ( slow_clk_hz )
    )
    i_slow_clk_gen
    (
        .clk          ( clk         ),
        .rst          ( rst         ),
        .slow_clk     ( slow_clk    )
    );

    lab_top
    #(
        .clk_mhz   ( clk_mhz   ),
        .w_key     ( w_key     ),
        .w_sw      ( w_sw      ),
        .w_led     ( w_led     ),
        .w_digit   ( w_digit   ),
        .w_refresh ( w_refresh )
    )
    i_lab_top
    (
        .clk       ( clk       ),
        .slow_clk  ( slow_clk  ),
        .rst       ( rst       ),

        .ctrl      ( ctrl      ),
        .key       ( lab_key   ),

        .led       ( lab_led   ),

        .abcdefgh  ( abcdefgh  ),
        .digit     ( lab_digit )
    );

    assign LED = lab_led;

    // Segment pins are wired in hgfedcba order
    assign hgfedcba = `SWAP_BITS (abcdefgh);

    assign HGFEDCBA = ~hgfedcba;
    assign DIGIT    = lab_digit;  // Digit enables stay active high

endmodule

// File: board_checker.sv
`timescale 1ns/1ps

module board_checker
#(
    parameter w_val = 32,
    parameter w_oh  = 8
)
(
    input logic               clk,
    input logic               rst,
    input logic [w_val - 1:0] value,
    input logic               change_en,
    input logic [w_oh - 1:0]  digit
);

    // Exactly one digit enable is lit at any time
    digit_one_hot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot (digit)
    ) else $error ("digit is not one-hot: %b", digit);

    // The watched value only moves on the cycle after its enable
    value_moves_on_enable : assert property (
        @(posedge clk) disable iff (rst)
        value != $past (value) |-> $past (change_en)
    ) else $error ("value changed without its enable: %h", value);

endmodule

// Digit index steps only at the end of a refresh period
bind seven_segment_display board_checker
#(
    .w_val     ( w_idx      ),
    .w_oh      ( w_digit    )
)
i_display_checker
(
    .clk       ( clk        ),
    .rst       ( rst        ),
    .value     ( digit_idx  ),
    .change_en ( step_digit ),
    .digit     ( digit      )
);

// Count steps only on a detected slow-clock rise
bind lab_top board_checker
#(
    .w_val     ( w_cnt      ),
    .w_oh      ( w_digit    )
)
i_count_checker
(
    .clk       ( clk        ),
    .rst       ( rst        ),
    .value     ( count      ),
    .change_en ( slow_rise  ),
    .digit     ( digit      )
);

// File: tb_board_top.sv
`timescale 1ns/1ps

`include "swap_bits.svh"

module tb_board_top;

    localparam int clk_mhz     = 1;
    localparam int slow_clk_hz = 50000;
    localparam int w_key       = 4;
    localparam int w_sw        = 16;
    localparam int w_led       = 16;
    localparam int w_digit     = 8;
    localparam int w_refresh   = 2;

    localparam int slow_period = clk_mhz * 1000000 / slow_clk_hz;  // Clock cycles per slow period
    localparam int scan_period = w_digit * (2 ** w_refresh);       // Cycles for one full scan
    localparam int n_steps     = 6;

    logic                 clk = 1'b0;
    logic [w_key - 1:0]   key;
    logic [w_sw - 1:0]    sw;
    logic [w_led - 1:0]   led;
    logic [7:0]           hgfedcba;
    logic [w_digit - 1:0] digit;

    logic [31:0]          lfsr = 32'hf866c39f;

    // Owned by the comparing process
    logic [31:0]          model;
    logic [31:0]          model_q;   // Count one cycle back, as the display registers it
    logic [31:0]          expected;
    logic [w_led - 1:0]   prev_led;
    logic [w_digit - 1:0] prev_digit;
    logic [w_key - 1:0]   prev_key;
    logic [w_sw - 1:0]    prev_sw;
    int                   pos;
    int                   led_changes = 0;
    int                   scan_wraps  = 0;
    int                   pos_hits [0:w_digit - 1];
    int                   cmp_errors  = 0;

    // Owned by the stimulus process
    int                   stim_errors = 0;
    int                   passed      = 0;
    int                   failed      = 0;

    always #5 clk = ~clk;

    board_specific_top
    #(
        .clk_mhz     ( clk_mhz     ),
        .slow_clk_hz ( slow_clk_hz ),
        .w_key       ( w_key       ),
        .w_sw        ( w_sw        ),
        .w_led       ( w_led       ),
        .w_digit     ( w_digit     ),
        .w_refresh   ( w_refresh   )
    )
    i_board_specific_top
    (
        .CLK         ( clk         ),
        .KEY         ( key         ),
        .SW          ( sw          ),
        .LED         ( led         ),
        .HGFEDCBA    ( hgfedcba    ),
        .DIGIT       ( digit       )
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step (input logic [31:0] state);
        return {state [30:0], state [31] ^ state [21] ^ state [1] ^ state [0]};
    endfunction

    // Reference for one slow-clock update of the lab counter
    function automatic logic [31:0] next_count (input logic [31:0] count, input logic [3:0] step,
                                                input logic pause, input logic down);
        if (pause)
            return count;
        if (down)
            return count - {28'd0, step};
        return count + {28'd0, step};
    endfunction

    // Expected active-low pin pattern, pins wired h down to a
    function automatic logic [7:0] seg_pins (input logic [3:0] hex);
        logic [7:0] segs;
        logic [7:0] pins;

        case (hex)
            4'h0: segs = 8'b1111_1100;
            4'h1: segs = 8'b0110_0000;
            4'h2: segs = 8'b1101_1010;
            4'h3: segs = 8'b1111_0010;
            4'h4: segs = 8'b0110_0110;
            4'h5: segs = 8'b1011_0110;
            4'h6: segs = 8'b1011_1110;
            4'h7: segs = 8'b1110_0000;
            4'h8: segs = 8'b1111_1110;
            4'h9: segs = 8'b1111_0110;
            4'ha: segs = 8'b1110_1110;
            4'hb: segs = 8'b0011_1110;
            4'hc: segs = 8'b1001_1100;
            4'hd: segs = 8'b0111_1010;
            4'he: segs = 8'b1001_1110;
            default: segs = 8'b1000_1110;
        endcase
        pins = `SWAP_BITS (segs);
        return ~pins;
    endfunction

    function automatic int digit_pos (input logic [w_digit - 1:0] onehot);
        int p;

        p = 0;
        for (int i = 0; i < w_digit; i++)
            if (onehot [i])
                p = i;
        return p;
    endfunction

    function automatic int total_errors ();
        return cmp_errors + stim_errors;
    endfunction

    // Comparing process, samples at the falling edge where outputs are stable
    always @(negedge clk) begin
        if (key [w_key - 1] == 1'b0) begin
            model      = '0;
            model_q    = '0;
            prev_led   = '0;
            prev_digit = w_digit' (1);
        end else begin
            assert ($onehot (digit)) else begin
                $display ("[ERROR] %0t ns: DIGIT %b is not one-hot", $time, digit);
                cmp_errors++;
            end
            if ($onehot (digit)) begin
                pos = digit_pos (digit);
                pos_hits [pos]++;
                assert (hgfedcba == seg_pins (model_q [pos * 4 +: 4])) else begin
                    $display ("[ERROR] %0t ns: digit %0d shows %b, expected %b", $time, pos,
                              hgfedcba, seg_pins (model_q [pos * 4 +: 4]));
                    cmp_errors++;
                end
            end
            if (digit != prev_digit) begin
                assert (digit == {prev_digit [w_digit - 2:0], prev_digit [w_digit - 1]}) else begin
                    $display ("[ERROR] %0t ns: DIGIT went %b to %b", $time, prev_digit, digit);
                    cmp_errors++;
                end
                if (prev_digit [w_digit - 1] && digit [0])
                    scan_wraps++;
            end
            if (led != prev_led) begin
                // Inputs seen one edge back are the ones the counter used
                expected = next_count (model, prev_sw [3:0], ~prev_key [0], ~prev_key [1]);
                assert (led == expected [w_led - 1:0]) else begin
                    $display ("[ERROR] %0t ns: LED %h, expected %h", $time, led,
                              expected [w_led - 1:0]);
                    cmp_errors++;
                end
                model = expected;
                led_changes++;
            end
            model_q    = model;
            prev_led   = led;
            prev_digit = digit;
        end
        prev_key = key;
        prev_sw  = sw;
    end

    task automatic take_bits (input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step (lfsr);
            bits = {bits [30:0], lfsr [0]};
        end
    endtask

    task automatic drive_ctrl (input logic pause, input logic down, output logic [3:0] step);
        logic [31:0] bits;

        take_bits (16, bits);
        step = bits [3:0] == 4'h0 ? 4'hf : bits [3:0];  // Zero step would hide updates
        @(posedge clk);
        key <= {2'b11, ~down, ~pause};
        sw  <= {bits [15:4], step};
    endtask

    task automatic wait_led_changes (input int n, input int max_cycles);
        int start;
        int cycles;

        start  = led_changes;
        cycles = 0;
        while (led_changes - start < n && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (led_changes - start < n) begin
            $display ("Timeout: LED changed %0d of %0d times in %0d cycles",
                      led_changes - start, n, max_cycles);
            stim_errors++;
        end
    endtask

    task automatic finish_test (input string name, input int err_start);
        if (total_errors () == err_start) begin
            passed++;
            $display ("test %s: pass", name);
        end else begin
            failed++;
            $display ("test %s: fail, %0d errors", name, total_errors () - err_start);
        end
    endtask

    initial begin
        logic [3:0] step;
        int         err_start;
        int         start;
        int         cycles;
        int         hits_start [0:w_digit - 1];
        logic       all_seen;

        key = 4'b0111;  // Reset key pressed
        sw  = '0;

        err_start = total_errors ();
        repeat (2) @(posedge clk);
        key <= 4'b1111;
        @(negedge clk);
        assert (led == '0) else begin
            $display ("[ERROR] %0t ns: LED %h after reset", $time, led);
            stim_errors++;
        end
        assert (digit == w_digit' (1)) else begin
            $display ("[ERROR] %0t ns: DIGIT %b after reset", $time, digit);
            stim_errors++;
        end
        assert (hgfedcba == seg_pins (4'h0)) else begin
            $display ("[ERROR] %0t ns: HGFEDCBA %b after reset", $time, hgfedcba);
            stim_errors++;
        end
        finish_test ("reset", err_start);

        err_start = total_errors ();
        drive_ctrl (1'b0, 1'b0, step);
        wait_led_changes (n_steps, (n_steps + 2) * slow_period);
        finish_test ($sformatf ("count up by %0d", step), err_start);

        err_start = total_errors ();
        drive_ctrl (1'b0, 1'b1, step);
        wait_led_changes (n_steps, (n_steps + 2) * slow_period);
        finish_test ($sformatf ("count down by %0d", step), err_start);

        err_start = total_errors ();
        drive_ctrl (1'b1, 1'b0, step);
        repeat (2) @(posedge clk);  // A rise on the press edge still counts
        start = led_changes;
        for (int w = 0; w < 3; w++) begin
            cycles = 0;
            while (led_changes == start && cycles < slow_period + 2) begin
                @(posedge clk);
                cycles++;
            end
            assert (led_changes == start) else begin
                $display ("[ERROR] %0t ns: LED moved while paused", $time);
                stim_errors++;
            end
        end
        finish_test ("pause", err_start);

        err_start = total_errors ();
        drive_ctrl (1'b0, 1'b1, step);
        hits_start = pos_hits;
        all_seen   = 1'b0;
        cycles     = 0;
        while (!all_seen && cycles < 3 * scan_period) begin
            @(posedge clk);
            cycles++;
            all_seen = 1'b1;
            for (int i = 0; i < w_digit; i++)
                if (pos_hits [i] == hits_start [i])
                    all_seen = 1'b0;
        end
        if (!all_seen) begin
            $display ("Timeout: not every digit was shown in %0d cycles", cycles);
            stim_errors++;
        end
        finish_test ("display", err_start);

        err_start = total_errors ();
        start     = scan_wraps;
        cycles    = 0;
        while (scan_wraps - start < 2 && cycles < 3 * scan_period) begin
            @(posedge clk);
            cycles++;
        end
        if (scan_wraps - start < 2) begin
            $display ("Timeout: digit scan did not wrap twice in %0d cycles", cycles);
            stim_errors++;
        end
        finish_test ("digit scan", err_start);

        $display ("tests %0d, passed %0d, failed %0d, errors %0d",
                  passed + failed, passed, failed, total_errors ());
        if (total_errors () == 0)
            $display ("Finished with no errors");
        else
            $display ("Finished with errors");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
board_pkg.sv
slow_clk_gen.sv
seven_segment_display.sv
lab_top.sv
board_specific_top.sv
board_checker.sv
tb_board_top.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_board_top -f vlog.f -o tb_board_top

run: compile
	@out="$$(./obj_dir/tb_board_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
